// ==== project.f ====
+incdir+source
source/mci_pkg.sv
source/mci_boot_sync_if.sv
source/mci_input_sync.sv
source/mci_boot_seqr.sv
source/mci_reset_status.sv
source/mci_boot_top.sv
tb/mci_boot_props.sv
tb/mci_boot_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the MCI boot sequencer testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/100ps \
  -f project.f --top-module mci_boot_tb -o mci_boot_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

out=$(./obj_dir/mci_boot_sim)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$out" | grep -qx "SIMULATION PASSED"; then
  exit 0
fi
exit 1

// ==== source/mci_boot_seqr.sv ====
// Boot state machine with reset outputs, init strobes and minimum reset counter
`timescale 1ns/100ps

module mci_boot_seqr (
  input  logic              clk,
  input  logic              mci_rst_b,
  mci_boot_sync_if.sync_dst sync_i,
  input  logic              caliptra_boot_go_i,
  input  logic              mcu_rst_req_i,
  input  logic              mcu_sram_fw_exec_region_lock_i,
  output logic              mcu_rst_b_o,
  output logic              cptra_rst_b_o,
  output logic              fc_opt_init_o,
  output logic              lc_init_o,
  output logic              mcu_rst_entry_o
);

  import mci_pkg::*;

  mci_boot_fsm_state_e boot_fsm;
  mci_boot_fsm_state_e boot_fsm_nxt;
  mci_boot_fsm_state_e boot_fsm_prev;

  logic mcu_rst_b_nxt;
  logic cptra_rst_b_nxt;
  logic fc_opt_init_nxt;
  logic lc_init_nxt;
  logic rst_mcu_enter;

  min_rst_cnt_t min_rst_cnt;
  logic         min_rst_elapsed;

  // Without ROM the first release also needs firmware locked in SRAM
  logic mcu_release_ok;

  assign mcu_release_ok = !sync_i.no_rom_config_sync || mcu_sram_fw_exec_region_lock_i;
  assign rst_mcu_enter  = (boot_fsm_nxt == BOOT_RST_MCU) && (boot_fsm != BOOT_RST_MCU);

  //////////////////////////////////////////////////////////////////////
  // State and output registers
  //////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk or negedge mci_rst_b) begin
    if (!mci_rst_b) begin
      boot_fsm        <= BOOT_IDLE;
      boot_fsm_prev   <= BOOT_IDLE;
      mcu_rst_b_o     <= 1'b0;
      cptra_rst_b_o   <= 1'b0;
      fc_opt_init_o   <= 1'b0;
      lc_init_o       <= 1'b0;
      mcu_rst_entry_o <= 1'b0;
    end else begin
      boot_fsm        <= boot_fsm_nxt;
      // Remember where the last transition came from
      if (boot_fsm != boot_fsm_nxt) begin
        boot_fsm_prev <= boot_fsm;
      end
      mcu_rst_b_o     <= mcu_rst_b_nxt;
      cptra_rst_b_o   <= cptra_rst_b_nxt;
      fc_opt_init_o   <= fc_opt_init_nxt;
      lc_init_o       <= lc_init_nxt;
      mcu_rst_entry_o <= rst_mcu_enter;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Next state logic
  //////////////////////////////////////////////////////////////////////
  always_comb begin
    boot_fsm_nxt    = boot_fsm;
    mcu_rst_b_nxt   = mcu_rst_b_o;
    cptra_rst_b_nxt = cptra_rst_b_o;
    fc_opt_init_nxt = fc_opt_init_o;
    lc_init_nxt     = lc_init_o;
    unique case (boot_fsm)
      BOOT_IDLE: begin
        boot_fsm_nxt = BOOT_OTP_FC;
      end
      BOOT_OTP_FC: begin
        fc_opt_init_nxt = 1'b1;
        if (sync_i.fc_opt_done_sync) begin
          boot_fsm_nxt = BOOT_LCC;
        end
      end
      BOOT_LCC: begin
        lc_init_nxt = 1'b1;
        if (sync_i.lc_done_sync) begin
          boot_fsm_nxt = BOOT_BREAKPOINT;
        end
      end
      BOOT_BREAKPOINT: begin
        if (!sync_i.brkpoint_sync && mcu_release_ok) begin
          boot_fsm_nxt = BOOT_MCU;
        end
      end
      BOOT_MCU: begin
        mcu_rst_b_nxt = 1'b1;
        // Caliptra is already running after an update reset
        if (boot_fsm_prev == BOOT_RST_MCU) begin
          boot_fsm_nxt = BOOT_WAIT_MCU_RST_REQ;
        end else begin
          boot_fsm_nxt = BOOT_WAIT_CLPA_GO;
        end
      end
      BOOT_WAIT_CLPA_GO: begin
        if (caliptra_boot_go_i) begin
          boot_fsm_nxt = BOOT_CPTRA;
        end
      end
      BOOT_CPTRA: begin
        cptra_rst_b_nxt = 1'b1;
        boot_fsm_nxt    = BOOT_WAIT_MCU_RST_REQ;
      end
      BOOT_WAIT_MCU_RST_REQ: begin
        if (mcu_rst_req_i) begin
          boot_fsm_nxt  = BOOT_RST_MCU;
          mcu_rst_b_nxt = 1'b0;
        end
      end
      BOOT_RST_MCU: begin
        mcu_rst_b_nxt = 1'b0;
        // Hold until min time is over and the new image is locked
        if (min_rst_elapsed && mcu_sram_fw_exec_region_lock_i) begin
          boot_fsm_nxt = BOOT_MCU;
        end
      end
      default: begin
        boot_fsm_nxt = BOOT_IDLE;
      end
    endcase
  end

  //////////////////////////////////////////////////////////////////////
  // Minimum MCU reset counter
  //////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk or negedge mci_rst_b) begin
    if (!mci_rst_b) begin
      min_rst_cnt     <= '0;
      min_rst_elapsed <= 1'b0;
    end else if (rst_mcu_enter) begin
      min_rst_cnt     <= '0;
      min_rst_elapsed <= 1'b0;
    end else if (boot_fsm == BOOT_RST_MCU) begin
      if (min_rst_cnt != '1) begin
        min_rst_cnt <= min_rst_cnt + 1'b1;
      end else begin
        // Saturated, min reset time reached
        min_rst_elapsed <= 1'b1;
      end
    end
  end

endmodule

// ==== source/mci_boot_sync_if.sv ====
// Interface for synchronized SoC boot inputs
`timescale 1ns/100ps

interface mci_boot_sync_if;

  // Plain levels, already in the clk domain
  logic lc_done_sync;
  logic fc_opt_done_sync;
  logic brkpoint_sync;
  logic no_rom_config_sync;

  // Driven by the input synchronizers
  modport sync_src (
    output lc_done_sync,
    output fc_opt_done_sync,
    output brkpoint_sync,
    output no_rom_config_sync
  );

  // Read by the boot sequencer
  modport sync_dst (
    input lc_done_sync,
    input fc_opt_done_sync,
    input brkpoint_sync,
    input no_rom_config_sync
  );

endinterface

// ==== source/mci_boot_top.sv ====
// Boot sequencer subsystem top with sync, FSM and reset status blocks
`timescale 1ns/100ps

module mci_boot_top (
  input  logic                  clk,
  input  logic                  mci_rst_b,
  input  logic                  lc_done_i,
  input  logic                  fc_opt_done_i,
  input  logic                  mci_boot_seq_brkpoint_i,
  input  logic                  mcu_no_rom_config_i,
  input  logic                  caliptra_boot_go_i,
  input  logic                  mcu_rst_req_i,
  input  logic                  mcu_sram_fw_exec_region_lock_i,
  output logic                  mcu_rst_b_o,
  output logic                  cptra_rst_b_o,
  output logic                  fc_opt_init_o,
  output logic                  lc_init_o,
  output logic                  mcu_reset_once_o,
  output logic                  fw_boot_upd_reset_o,
  output logic                  fw_hitless_upd_reset_o,
  output mci_pkg::hitless_cnt_t hitless_cnt_o
);

  // One cycle pulse on entry to MCU reset
  logic mcu_rst_entry;

  mci_boot_sync_if u_sync_if ();

  mci_input_sync u_input_sync (
    .clk                     (clk),
    .mci_rst_b               (mci_rst_b),
    .lc_done_i               (lc_done_i),
    .fc_opt_done_i           (fc_opt_done_i),
    .mci_boot_seq_brkpoint_i (mci_boot_seq_brkpoint_i),
    .mcu_no_rom_config_i     (mcu_no_rom_config_i),
    .sync_o                  (u_sync_if.sync_src)
  );

  mci_boot_seqr u_boot_seqr (
    .clk                            (clk),
    .mci_rst_b                      (mci_rst_b),
    .sync_i                         (u_sync_if.sync_dst),
    .caliptra_boot_go_i             (caliptra_boot_go_i),
    .mcu_rst_req_i                  (mcu_rst_req_i),
    .mcu_sram_fw_exec_region_lock_i (mcu_sram_fw_exec_region_lock_i),
    .mcu_rst_b_o                    (mcu_rst_b_o),
    .cptra_rst_b_o                  (cptra_rst_b_o),
    .fc_opt_init_o                  (fc_opt_init_o),
    .lc_init_o                      (lc_init_o),
    .mcu_rst_entry_o                (mcu_rst_entry)
  );

  mci_reset_status u_reset_status (
    .clk                    (clk),
    .mci_rst_b              (mci_rst_b),
    .mcu_rst_entry_i        (mcu_rst_entry),
    .mcu_reset_once_o       (mcu_reset_once_o),
    .fw_boot_upd_reset_o    (fw_boot_upd_reset_o),
    .fw_hitless_upd_reset_o (fw_hitless_upd_reset_o),
    .hitless_cnt_o          (hitless_cnt_o)
  );

endmodule

// ==== source/mci_defines.svh ====
// Boot sequencer width and depth constants
`ifndef MCI_DEFINES_SVH
`define MCI_DEFINES_SVH

// Minimum MCU reset time is 2**width cycles
`define MCI_MIN_RST_CNT_W 4

// Flops per synchronizer chain
`define MCI_SYNC_STAGES 2

// Hitless firmware update counter width
`define MCI_HITLESS_CNT_W 8

`endif

// ==== source/mci_input_sync.sv ====
// Multi-stage synchronizers for asynchronous SoC boot inputs
`timescale 1ns/100ps
`include "mci_defines.svh"

module mci_input_sync (
  input  logic                     clk,
  input  logic                     mci_rst_b,
  input  logic                     lc_done_i,
  input  logic                     fc_opt_done_i,
  input  logic                     mci_boot_seq_brkpoint_i,
  input  logic                     mcu_no_rom_config_i,
  mci_boot_sync_if.sync_src        sync_o
);

  // One bit per input, one row per stage
  logic [3:0]                         raw_in;
  logic [`MCI_SYNC_STAGES-1:0][3:0]   sync_ff;

  assign raw_in = {mcu_no_rom_config_i, mci_boot_seq_brkpoint_i,
                   fc_opt_done_i, lc_done_i};

  //////////////////////////////////////////////////////////////////////
  // Synchronizer chains
  //////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk or negedge mci_rst_b) begin
    if (!mci_rst_b) begin
      sync_ff <= '0;
    end else begin
      sync_ff[0] <= raw_in;
      for (int i = 1; i < `MCI_SYNC_STAGES; i++) begin
        sync_ff[i] <= sync_ff[i-1];
      end
    end
  end

  // Last stage feeds the boot sequencer
  assign sync_o.lc_done_sync       = sync_ff[`MCI_SYNC_STAGES-1][0];
  assign sync_o.fc_opt_done_sync   = sync_ff[`MCI_SYNC_STAGES-1][1];
  assign sync_o.brkpoint_sync      = sync_ff[`MCI_SYNC_STAGES-1][2];
  assign sync_o.no_rom_config_sync = sync_ff[`MCI_SYNC_STAGES-1][3];

endmodule

// ==== source/mci_pkg.sv ====
// Boot state enum and counter vector types
`include "mci_defines.svh"

package mci_pkg;

  // Boot sequencer states, in boot order
  typedef enum logic [3:0] {
    BOOT_IDLE             = 4'd0,
    BOOT_OTP_FC           = 4'd1,
    BOOT_LCC              = 4'd2,
    BOOT_BREAKPOINT       = 4'd3,
    BOOT_MCU              = 4'd4,
    BOOT_WAIT_CLPA_GO     = 4'd5,
    BOOT_CPTRA            = 4'd6,
    BOOT_WAIT_MCU_RST_REQ = 4'd7,
    BOOT_RST_MCU          = 4'd8
  } mci_boot_fsm_state_e;

  // Minimum MCU reset counter
  typedef logic [`MCI_MIN_RST_CNT_W-1:0] min_rst_cnt_t;

  // Number of hitless firmware updates seen
  typedef logic [`MCI_HITLESS_CNT_W-1:0] hitless_cnt_t;

endpackage

// ==== source/mci_reset_status.sv ====
// MCU reset classification flags and hitless update counter
`timescale 1ns/100ps

module mci_reset_status (
  input  logic                 clk,
  input  logic                 mci_rst_b,
  input  logic                 mcu_rst_entry_i,
  output logic                 mcu_reset_once_o,
  output logic                 fw_boot_upd_reset_o,
  output logic                 fw_hitless_upd_reset_o,
  output mci_pkg::hitless_cnt_t hitless_cnt_o
);

  //////////////////////////////////////////////////////////////////////
  // Reset classification
  //////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk or negedge mci_rst_b) begin
    if (!mci_rst_b) begin
      mcu_reset_once_o       <= 1'b0;
      fw_boot_upd_reset_o    <= 1'b0;
      fw_hitless_upd_reset_o <= 1'b0;
      hitless_cnt_o          <= '0;
    end else if (mcu_rst_entry_i) begin
      if (!mcu_reset_once_o) begin
        // First reset loads the firmware boot image
        mcu_reset_once_o    <= 1'b1;
        fw_boot_upd_reset_o <= 1'b1;
      end else begin
        // Every later reset is a hitless update
        fw_boot_upd_reset_o    <= 1'b0;
        fw_hitless_upd_reset_o <= 1'b1;
        if (hitless_cnt_o != '1) begin
          hitless_cnt_o <= hitless_cnt_o + 1'b1;
        end
      end
    end
  end

endmodule

// ==== tb/mci_boot_props.sv ====
// Concurrent assertions on the boot sequencer reset outputs and entry pulse
`timescale 1ns/100ps
`include "mci_defines.svh"

module mci_boot_props (
  input logic                 clk,
  input logic                 mci_rst_b,
  input logic                 mcu_rst_b_o,
  input logic                 cptra_rst_b_o,
  input logic                 mcu_rst_entry_o,
  input mci_pkg::min_rst_cnt_t min_rst_cnt
);

  // MCU held in reset while the entry pulse is high
  a_entry_in_reset: assert property (@(posedge clk) disable iff (!mci_rst_b)
    mcu_rst_entry_o |-> !mcu_rst_b_o)
    else $error("MCU reset released during the entry pulse");

  // Entry pulse is a single cycle
  a_entry_one_cycle: assert property (@(posedge clk) disable iff (!mci_rst_b)
    mcu_rst_entry_o |=> !mcu_rst_entry_o)
    else $error("MCU reset entry pulse longer than one cycle");

  // Caliptra stays out of reset until the next MCI reset
  a_cptra_sticky: assert property (@(posedge clk) disable iff (!mci_rst_b)
    cptra_rst_b_o |=> (cptra_rst_b_o || !mci_rst_b))
    else $error("Caliptra reset asserted again after release");

  // An update release only comes once the counter has saturated
  a_min_rst_time: assert property (@(posedge clk) disable iff (!mci_rst_b)
    $rose(mcu_rst_b_o) && cptra_rst_b_o |-> min_rst_cnt == {`MCI_MIN_RST_CNT_W{1'b1}})
    else $error("MCU released before the minimum reset time");

endmodule

bind mci_boot_seqr mci_boot_props u_props (
  .clk             (clk),
  .mci_rst_b       (mci_rst_b),
  .mcu_rst_b_o     (mcu_rst_b_o),
  .cptra_rst_b_o   (cptra_rst_b_o),
  .mcu_rst_entry_o (mcu_rst_entry_o),
  .min_rst_cnt     (min_rst_cnt)
);

// ==== tb/mci_boot_stimulus.txt ====
# test brk_hold no_rom lock_delay extra_updates exp_hitless_cnt   (all decimal)
# lock_delay is how long the region lock stays low, in cycles, at no-ROM boot and per update
1 0 0 0 0 0
2 12 0 5 1 1
3 3 1 10 2 2
4 0 1 30 3 3
5 25 0 22 5 5
6 8 1 1 0 0

// ==== tb/mci_boot_tb.sv ====
// Testbench for the MCI boot sequencer, scenarios read from a stimulus file
`timescale 1ns/100ps
`include "mci_defines.svh"

module mci_boot_tb;

  import mci_pkg::*;

  localparam int TIMEOUT = 500;
  // Counter runs 2**W cycles, plus the entry and release registers
  localparam int MIN_LOW = (1 << `MCI_MIN_RST_CNT_W) + 2;
  localparam int MCU_RST = 0;
  localparam int CPTRA_RST = 1;
  localparam int FC_INIT = 2;
  localparam int LC_INIT = 3;

  logic clk;
  logic mci_rst_b;
  logic lc_done, fc_opt_done, brkpoint, no_rom;
  logic clpa_go, rst_req, lock;
  logic mcu_rst_b, cptra_rst_b, fc_opt_init, lc_init;
  logic rst_once, boot_upd, hitless_upd;
  hitless_cnt_t hitless_cnt;

  string name;
  int    test_errs;
  bit    timed_out;

  mci_boot_top uut (
    .clk                            (clk),
    .mci_rst_b                      (mci_rst_b),
    .lc_done_i                      (lc_done),
    .fc_opt_done_i                  (fc_opt_done),
    .mci_boot_seq_brkpoint_i        (brkpoint),
    .mcu_no_rom_config_i            (no_rom),
    .caliptra_boot_go_i             (clpa_go),
    .mcu_rst_req_i                  (rst_req),
    .mcu_sram_fw_exec_region_lock_i (lock),
    .mcu_rst_b_o                    (mcu_rst_b),
    .cptra_rst_b_o                  (cptra_rst_b),
    .fc_opt_init_o                  (fc_opt_init),
    .lc_init_o                      (lc_init),
    .mcu_reset_once_o               (rst_once),
    .fw_boot_upd_reset_o            (boot_upd),
    .fw_hitless_upd_reset_o         (hitless_upd),
    .hitless_cnt_o                  (hitless_cnt)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  //////////////////////////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////////////////////////
  function automatic logic out_bit(input int sel);
    case (sel)
      MCU_RST:   return mcu_rst_b;
      CPTRA_RST: return cptra_rst_b;
      FC_INIT:   return fc_opt_init;
      default:   return lc_init;
    endcase
  endfunction

  task automatic report_error(input string what, input int exp, input int act);
    $display("error %s %s: expected %0d actual %0d", name, what, exp, act);
    test_errs++;
  endtask

  task automatic timeout_fail(input string what);
    $display("%s: no %s within %0d cycles", name, what, TIMEOUT);
    test_errs++;
    timed_out = 1'b1;
  endtask

  task automatic wait_out(input int sel, input logic val, input string what);
    int waited;
    waited = 0;
    while (out_bit(sel) !== val && waited < TIMEOUT) begin
      @(posedge clk);
      waited++;
    end
    if (out_bit(sel) !== val) timeout_fail(what);
  endtask

  // Output must stay low for a fixed number of cycles
  task automatic hold_low(input int sel, input int cycles, input string what);
    repeat (cycles) begin
      if (out_bit(sel) !== 1'b0) begin
        report_error(what, 0, int'(out_bit(sel)));
        return;
      end
      @(posedge clk);
    end
  endtask

  // One update reset, returns how many cycles mcu_rst_b was low
  task automatic mcu_update(input int lock_dly, output int low);
    int waited;
    low = 0;
    waited = 0;
    rst_req <= 1'b1;
    lock    <= (lock_dly == 0);
    @(posedge clk);
    rst_req <= 1'b0;
    wait_out(MCU_RST, 1'b0, "mcu_rst_b fall");
    if (timed_out) return;
    while (mcu_rst_b === 1'b0 && waited < TIMEOUT) begin
      low++;
      if (low == lock_dly) lock <= 1'b1;
      @(posedge clk);
      waited++;
    end
    if (mcu_rst_b !== 1'b1) timeout_fail("mcu_rst_b release after update");
  endtask

  //////////////////////////////////////////////////////////////////////
  // One scenario from boot through the update resets
  //////////////////////////////////////////////////////////////////////
  task automatic run_test(input int brk_hold, input int rom_less, input int lock_dly,
                          input int n_upd, input int exp_cnt);
    int low;
    timed_out = 1'b0;
    @(posedge clk);
    mci_rst_b   <= 1'b0;
    fc_opt_done <= 1'b0;
    lc_done     <= 1'b0;
    brkpoint    <= (brk_hold > 0);
    no_rom      <= (rom_less != 0);
    clpa_go     <= 1'b0;
    rst_req     <= 1'b0;
    lock        <= !(rom_less != 0 && lock_dly > 0);
    repeat (5) @(posedge clk);
    if ({mcu_rst_b, cptra_rst_b, fc_opt_init, lc_init} !== 4'b0)
      report_error("controls in reset", 0, int'({mcu_rst_b, cptra_rst_b, fc_opt_init, lc_init}));
    mci_rst_b <= 1'b1;
    wait_out(FC_INIT, 1'b1, "fc_opt_init");
    if (timed_out) return;
    hold_low(LC_INIT, 4, "lc_init before fc_opt_done");
    fc_opt_done <= 1'b1;
    wait_out(LC_INIT, 1'b1, "lc_init");
    if (timed_out) return;
    lc_done <= 1'b1;
    hold_low(MCU_RST, brk_hold, "mcu_rst_b during breakpoint");
    brkpoint <= 1'b0;
    if (rom_less != 0) begin
      hold_low(MCU_RST, lock_dly, "mcu_rst_b before region lock");
      lock <= 1'b1;
    end
    wait_out(MCU_RST, 1'b1, "mcu_rst_b release");
    if (timed_out) return;
    hold_low(CPTRA_RST, 4, "cptra_rst_b before boot go");
    clpa_go <= 1'b1;
    wait_out(CPTRA_RST, 1'b1, "cptra_rst_b release");
    if (timed_out) return;

    // First update reset loads the boot image
    mcu_update(lock_dly, low);
    if (timed_out) return;
    if (low < MIN_LOW) report_error("first reset length", MIN_LOW, low);
    if (low <= lock_dly) report_error("first reset past lock", lock_dly + 1, low);
    if (boot_upd !== 1'b1) report_error("fw_boot_upd_reset", 1, int'(boot_upd));
    if (rst_once !== 1'b1) report_error("mcu_reset_once", 1, int'(rst_once));
    if (hitless_upd !== 1'b0) report_error("fw_hitless_upd_reset", 0, int'(hitless_upd));

    repeat (n_upd) begin
      mcu_update(lock_dly, low);
      if (timed_out) return;
      if (low < MIN_LOW) report_error("update reset length", MIN_LOW, low);
    end
    if (hitless_upd !== (n_upd > 0))
      report_error("final fw_hitless_upd_reset", int'(n_upd > 0), int'(hitless_upd));
    if (boot_upd !== (n_upd == 0))
      report_error("final fw_boot_upd_reset", int'(n_upd == 0), int'(boot_upd));
    if (int'(hitless_cnt) != exp_cnt) report_error("hitless_cnt", exp_cnt, int'(hitless_cnt));
  endtask

  //////////////////////////////////////////////////////////////////////
  // Main sequence
  //////////////////////////////////////////////////////////////////////
  initial begin
    int    fd;
    int    n;
    int    tests;
    int    fails;
    int    t_num, brk, nr, ld, nu, ec;
    string line;
    tests = 0;
    fails = 0;
    mci_rst_b   = 1'b0;
    lc_done     = 1'b0;
    fc_opt_done = 1'b0;
    brkpoint    = 1'b0;
    no_rom      = 1'b0;
    clpa_go     = 1'b0;
    rst_req     = 1'b0;
    lock        = 1'b0;
    fd = $fopen("tb/mci_boot_stimulus.txt", "r");
    if (fd == 0) begin
      $display("could not open the stimulus file tb/mci_boot_stimulus.txt");
    end else begin
      while (!$feof(fd)) begin
        line = "";
        void'($fgets(line, fd));
        if (line.len() == 0 || line[0] == "#") continue;
        n = $sscanf(line, "%d %d %d %d %d %d", t_num, brk, nr, ld, nu, ec);
        if (n != 6) continue;
        name = $sformatf("test_%0d", t_num);
        test_errs = 0;
        run_test(brk, nr, ld, nu, ec);
        tests++;
        if (test_errs == 0) begin
          $display("%s passed", name);
        end else begin
          $display("%s failed with %0d errors", name, test_errs);
          fails++;
        end
      end
      $fclose(fd);
    end
    $display("tests run %0d, passed %0d, failed %0d", tests, tests - fails, fails);
    if (fails == 0 && tests > 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule
